// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mini_core_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS
FAIL_MSG  = Simulation finished: FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/commit_queue.sv
/*
 * commit queue: small FIFO for commit records under back-pressure,
 * push and pop allowed in one cycle
 */

`timescale 1ns/10ps

`include "core_consts.svh"

module commit_queue (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_val,
  output logic                  in_rdy,
  input  core_pkg::commit_msg_t in_msg,
  output logic                  out_val,
  input  logic                  out_rdy,
  output core_pkg::commit_msg_t out_msg
);

  localparam int depth    = `CORE_CQ_DEPTH;
  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_bits = $clog2(depth + 1);

  core_pkg::commit_msg_t mem [depth];
  logic [ptr_bits-1:0]   wr_ptr;
  logic [ptr_bits-1:0]   rd_ptr;
  logic [cnt_bits-1:0]   count;
  logic                  full;
  logic                  empty;
  logic                  push;
  logic                  pop;

  // wrap without assuming a power of two
  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] p);
    return (p == ptr_bits'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = (count == cnt_bits'(depth));
  assign empty   = (count == '0);
  assign in_rdy  = !full;
  assign out_val = !empty;
  assign out_msg = mem[rd_ptr];
  assign push    = in_val && in_rdy;
  assign pop     = out_val && out_rdy;

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) count <= count + cnt_bits'(1);
      else if (pop && !push) count <= count - cnt_bits'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_msg;
  end

endmodule

// File: design/core_consts.svh
/*
 * core constants: data width, register file size, RV32I opcode and
 * funct encodings for the supported subset, commit queue depth
 */

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath
`define CORE_XLEN       32
`define CORE_NREGS      32
`define CORE_REG_BITS   5

// ----------------------------------------
// major opcodes
`define CORE_OP_RTYPE   7'b0110011
`define CORE_OP_ITYPE   7'b0010011
`define CORE_OP_BRANCH  7'b1100011

// funct3, alu ops shared by r and i forms
`define CORE_F3_ADD     3'b000
`define CORE_F3_XOR     3'b100
`define CORE_F3_OR      3'b110
`define CORE_F3_AND     3'b111
// funct3, branches
`define CORE_F3_BEQ     3'b000
`define CORE_F3_BNE     3'b001

// funct7
`define CORE_F7_BASE    7'b0000000
`define CORE_F7_SUB     7'b0100000

// output queue
`define CORE_CQ_DEPTH   2

`endif

// File: design/core_pkg.sv
/*
 * shared core types: instruction word views, micro-op encoding and
 * the messages that travel between decode, execute and commit
 */

`include "core_consts.svh"

package core_pkg;

  // ----------------------------------------
  // instruction formats, all 32 bits
  typedef struct packed {
    logic [6:0]                funct7;
    logic [`CORE_REG_BITS-1:0] rs2;
    logic [`CORE_REG_BITS-1:0] rs1;
    logic [2:0]                funct3;
    logic [`CORE_REG_BITS-1:0] rd;
    logic [6:0]                opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]               imm12;
    logic [`CORE_REG_BITS-1:0] rs1;
    logic [2:0]                funct3;
    logic [`CORE_REG_BITS-1:0] rd;
    logic [6:0]                opcode;
  } i_fmt_t;

  // branch offset scattered over two fields
  typedef struct packed {
    logic                      imm12;
    logic [5:0]                imm10_5;
    logic [`CORE_REG_BITS-1:0] rs2;
    logic [`CORE_REG_BITS-1:0] rs1;
    logic [2:0]                funct3;
    logic [3:0]                imm4_1;
    logic                      imm11;
    logic [6:0]                opcode;
  } b_fmt_t;

  // field layout picked by opcode
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
  } inst_u;

  // i-type forms reuse the alu ops
  typedef enum logic [3:0] {
    uop_add, uop_sub, uop_and, uop_or, uop_xor, uop_beq, uop_bne, uop_nop
  } uop_e;

  // ----------------------------------------
  // stream messages
  typedef struct packed {
    logic [`CORE_XLEN-1:0] pc;
    inst_u                 inst;
  } fetch_msg_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]     pc;
    logic [`CORE_XLEN-1:0]     op1;
    logic [`CORE_XLEN-1:0]     op2;
    logic [`CORE_XLEN-1:0]     br_off;
    logic [`CORE_REG_BITS-1:0] rd;
    uop_e                      uop;
  } dx_msg_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]     pc;
    logic [`CORE_REG_BITS-1:0] rd;
    logic [`CORE_XLEN-1:0]     value;
  } commit_msg_t;

  // side channels out of execute
  typedef struct packed {
    logic                  squash;
    logic [`CORE_XLEN-1:0] branch_target;
  } redirect_t;

  typedef struct packed {
    logic                      wen;
    logic [`CORE_REG_BITS-1:0] waddr;
    logic [`CORE_XLEN-1:0]     wdata;
  } wb_t;

endpackage

// File: design/decode_stage.sv
/*
 * decode stage: accepts the fetch stream, decodes into a micro-op,
 * reads operands, stalls on the execute hazard, drops wrong-path words
 */

`timescale 1ns/10ps

`include "core_consts.svh"

module decode_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inst_val,
  output logic                      inst_rdy,
  input  core_pkg::fetch_msg_t      inst_msg,
  output logic                      dx_val,
  input  logic                      dx_rdy,
  output core_pkg::dx_msg_t         dx_msg,
  input  core_pkg::redirect_t       redirect,
  input  logic [`CORE_REG_BITS-1:0] ex_busy_rd,
  output logic [`CORE_REG_BITS-1:0] rs1,
  output logic [`CORE_REG_BITS-1:0] rs2,
  input  logic [`CORE_XLEN-1:0]     rd1,
  input  logic [`CORE_XLEN-1:0]     rd2
);

  // decoded word held in the slot
  typedef struct packed {
    logic [`CORE_XLEN-1:0]     pc;
    core_pkg::uop_e            uop;
    logic [`CORE_REG_BITS-1:0] rd;
    logic [`CORE_REG_BITS-1:0] rs1;
    logic [`CORE_REG_BITS-1:0] rs2;
    logic                      use_imm;
    logic [`CORE_XLEN-1:0]     imm;
  } dec_slot_t;

  core_pkg::inst_u       inst;
  dec_slot_t             dec;
  dec_slot_t             slot;
  logic                  slot_val;
  logic                  discard_q;
  logic [`CORE_XLEN-1:0] target_q;
  logic                  keep_slot;
  logic                  flush_slot;
  logic                  discard;
  logic [`CORE_XLEN-1:0] target;
  logic                  hazard;
  logic                  dx_fire;
  logic                  in_fire;
  logic                  hit;
  logic                  load;

  // funct3 to alu op, same table for r and i forms
  function automatic core_pkg::uop_e alu_uop(input logic [2:0] f3);
    case (f3)
      `CORE_F3_ADD: return core_pkg::uop_add;
      `CORE_F3_XOR: return core_pkg::uop_xor;
      `CORE_F3_OR:  return core_pkg::uop_or;
      `CORE_F3_AND: return core_pkg::uop_and;
      default:      return core_pkg::uop_nop;
    endcase
  endfunction

  assign inst = inst_msg.inst;

  // ----------------------------------------
  // instruction decode
  always_comb begin
    dec     = '0;
    dec.pc  = inst_msg.pc;
    dec.uop = core_pkg::uop_nop;
    case (inst.r_fmt.opcode)
      `CORE_OP_RTYPE: begin
        dec.rd  = inst.r_fmt.rd;
        dec.rs1 = inst.r_fmt.rs1;
        dec.rs2 = inst.r_fmt.rs2;
        if (inst.r_fmt.funct7 == `CORE_F7_BASE) begin
          dec.uop = alu_uop(inst.r_fmt.funct3);
        end else if (inst.r_fmt.funct7 == `CORE_F7_SUB &&
                     inst.r_fmt.funct3 == `CORE_F3_ADD) begin
          dec.uop = core_pkg::uop_sub;
        end
      end
      `CORE_OP_ITYPE: begin
        // op2 comes from the sign-extended immediate
        dec.rd      = inst.i_fmt.rd;
        dec.rs1     = inst.i_fmt.rs1;
        dec.use_imm = 1'b1;
        dec.imm     = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
        dec.uop     = alu_uop(inst.i_fmt.funct3);
      end
      `CORE_OP_BRANCH: begin
        dec.rs1 = inst.b_fmt.rs1;
        dec.rs2 = inst.b_fmt.rs2;
        dec.imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                   inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
        if (inst.b_fmt.funct3 == `CORE_F3_BEQ) dec.uop = core_pkg::uop_beq;
        else if (inst.b_fmt.funct3 == `CORE_F3_BNE) dec.uop = core_pkg::uop_bne;
      end
      default: dec.uop = core_pkg::uop_nop;
    endcase
    // unknown encodings commit as rd 0, value 0
    if (dec.uop == core_pkg::uop_nop) begin
      dec.rd      = '0;
      dec.rs1     = '0;
      dec.rs2     = '0;
      dec.use_imm = 1'b0;
      dec.imm     = '0;
    end
  end

  // ----------------------------------------
  // squash and wrong-path filter
  // slot survives only if it already holds the target
  assign keep_slot  = slot_val && (slot.pc == redirect.branch_target);
  assign flush_slot = redirect.squash && !keep_slot;
  assign discard    = discard_q || flush_slot;
  assign target     = redirect.squash ? redirect.branch_target : target_q;

  // stall while execute still owes a source register
  assign hazard = (ex_busy_rd != '0) &&
                  ((ex_busy_rd == slot.rs1) || (ex_busy_rd == slot.rs2));

  assign dx_val   = slot_val && !hazard && !redirect.squash;
  assign dx_fire  = dx_val && dx_rdy;
  assign inst_rdy = !slot_val || dx_fire || flush_slot;
  assign in_fire  = inst_val && inst_rdy;
  assign hit      = (inst_msg.pc == target);
  assign load     = in_fire && (!discard || hit);

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_val  <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      if (load) slot_val <= 1'b1;
      else if (dx_fire || flush_slot) slot_val <= 1'b0;
      // cleared once the target pc shows up
      discard_q <= discard && !(in_fire && hit);
    end
  end

  always_ff @(posedge clk) begin
    if (load) slot <= dec;
    if (redirect.squash) target_q <= redirect.branch_target;
  end

  // ----------------------------------------
  // operand read and outgoing message
  assign rs1 = slot.rs1;
  assign rs2 = slot.rs2;

  always_comb begin
    dx_msg.pc  = slot.pc;
    dx_msg.op1 = rd1;
    dx_msg.op2 = slot.use_imm ? slot.imm : rd2;
    dx_msg.rd  = slot.rd;
    dx_msg.uop = slot.uop;
    // offset only meaningful for branches
    if (slot.uop == core_pkg::uop_beq || slot.uop == core_pkg::uop_bne) begin
      dx_msg.br_off = slot.imm;
    end else begin
      dx_msg.br_off = '0;
    end
  end

endmodule

// File: design/execute_stage.sv
/*
 * execute stage: alu, branch resolution, squash to decode,
 * writeback to the register file and the commit record stream
 */

`timescale 1ns/10ps

`include "core_consts.svh"

module execute_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      dx_val,
  output logic                      dx_rdy,
  input  core_pkg::dx_msg_t         dx_msg,
  output logic [`CORE_REG_BITS-1:0] ex_busy_rd,
  output core_pkg::redirect_t       redirect,
  output core_pkg::wb_t             wb,
  output logic                      cm_val,
  input  logic                      cm_rdy,
  output core_pkg::commit_msg_t     cm_msg
);

  // result held until the queue takes it
  typedef struct packed {
    core_pkg::commit_msg_t rec;
    logic                  wen;
    logic                  taken;
    logic [`CORE_XLEN-1:0] target;
  } ex_slot_t;

  ex_slot_t              nxt;
  ex_slot_t              slot;
  logic                  ex_val;
  logic                  handoff;
  logic                  dx_fire;
  logic [`CORE_XLEN-1:0] seq_pc;
  logic [`CORE_XLEN-1:0] br_pc;

  // ----------------------------------------
  // alu and branch compare
  assign seq_pc = dx_msg.pc + `CORE_XLEN'(4);
  assign br_pc  = dx_msg.pc + dx_msg.br_off;

  always_comb begin
    nxt.rec.pc    = dx_msg.pc;
    nxt.rec.rd    = dx_msg.rd;
    nxt.rec.value = '0;
    nxt.wen       = 1'b0;
    nxt.taken     = 1'b0;
    nxt.target    = br_pc;
    case (dx_msg.uop)
      core_pkg::uop_add: begin
        nxt.rec.value = dx_msg.op1 + dx_msg.op2;
        nxt.wen       = 1'b1;
      end
      core_pkg::uop_sub: begin
        nxt.rec.value = dx_msg.op1 - dx_msg.op2;
        nxt.wen       = 1'b1;
      end
      core_pkg::uop_and: begin
        nxt.rec.value = dx_msg.op1 & dx_msg.op2;
        nxt.wen       = 1'b1;
      end
      core_pkg::uop_or: begin
        nxt.rec.value = dx_msg.op1 | dx_msg.op2;
        nxt.wen       = 1'b1;
      end
      core_pkg::uop_xor: begin
        nxt.rec.value = dx_msg.op1 ^ dx_msg.op2;
        nxt.wen       = 1'b1;
      end
      // branches commit the next pc
      core_pkg::uop_beq: begin
        nxt.taken     = (dx_msg.op1 == dx_msg.op2);
        nxt.rec.value = nxt.taken ? br_pc : seq_pc;
      end
      core_pkg::uop_bne: begin
        nxt.taken     = (dx_msg.op1 != dx_msg.op2);
        nxt.rec.value = nxt.taken ? br_pc : seq_pc;
      end
      default: nxt.rec.value = '0;
    endcase
  end

  // ----------------------------------------
  // single slot
  assign handoff = ex_val && cm_rdy;
  assign dx_rdy  = !ex_val || handoff;
  assign dx_fire = dx_val && dx_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_val <= 1'b0;
    end else if (dx_fire) begin
      ex_val <= 1'b1;
    end else if (handoff) begin
      ex_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dx_fire) slot <= nxt;
  end

  assign cm_val = ex_val;
  assign cm_msg = slot.rec;

  // writeback and redirect ride the handoff edge
  assign wb.wen   = handoff && slot.wen;
  assign wb.waddr = slot.rec.rd;
  assign wb.wdata = slot.rec.value;

  assign redirect.squash        = handoff && slot.taken;
  assign redirect.branch_target = slot.target;

  // busy until written back, bypass covers the handoff cycle
  assign ex_busy_rd = (ex_val && !cm_rdy && slot.wen) ? slot.rec.rd : '0;

endmodule

// File: design/mini_core.sv
/*
 * mini core top: decode with register file, execute, commit queue
 */

`timescale 1ns/10ps

`include "core_consts.svh"

module mini_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_val,
  output logic                  inst_rdy,
  input  core_pkg::fetch_msg_t  inst_msg,
  output logic                  commit_val,
  input  logic                  commit_rdy,
  output core_pkg::commit_msg_t commit_msg
);

  // ----------------------------------------
  // stage to stage wiring
  logic                      dx_val;
  logic                      dx_rdy;
  core_pkg::dx_msg_t         dx_msg;
  core_pkg::redirect_t       redirect;
  logic [`CORE_REG_BITS-1:0] ex_busy_rd;
  logic [`CORE_REG_BITS-1:0] rs1;
  logic [`CORE_REG_BITS-1:0] rs2;
  logic [`CORE_XLEN-1:0]     rd1;
  logic [`CORE_XLEN-1:0]     rd2;
  core_pkg::wb_t             wb;
  logic                      cm_val;
  logic                      cm_rdy;
  core_pkg::commit_msg_t     cm_msg;

  // input side
  decode_stage decode_i (
    .clk        (clk),
    .rst        (rst),
    .inst_val   (inst_val),
    .inst_rdy   (inst_rdy),
    .inst_msg   (inst_msg),
    .dx_val     (dx_val),
    .dx_rdy     (dx_rdy),
    .dx_msg     (dx_msg),
    .redirect   (redirect),
    .ex_busy_rd (ex_busy_rd),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd1        (rd1),
    .rd2        (rd2)
  );

  reg_file reg_file_i (
    .clk (clk),
    .rst (rst),
    .rs1 (rs1),
    .rs2 (rs2),
    .rd1 (rd1),
    .rd2 (rd2),
    .wb  (wb)
  );

  // processing
  execute_stage execute_i (
    .clk        (clk),
    .rst        (rst),
    .dx_val     (dx_val),
    .dx_rdy     (dx_rdy),
    .dx_msg     (dx_msg),
    .ex_busy_rd (ex_busy_rd),
    .redirect   (redirect),
    .wb         (wb),
    .cm_val     (cm_val),
    .cm_rdy     (cm_rdy),
    .cm_msg     (cm_msg)
  );

  // output side
  commit_queue commit_queue_i (
    .clk     (clk),
    .rst     (rst),
    .in_val  (cm_val),
    .in_rdy  (cm_rdy),
    .in_msg  (cm_msg),
    .out_val (commit_val),
    .out_rdy (commit_rdy),
    .out_msg (commit_msg)
  );

endmodule

// File: design/reg_file.sv
/*
 * integer register file, two combinational read ports, one write port,
 * x0 fixed at zero, same-cycle write bypass
 */

`timescale 1ns/10ps

`include "core_consts.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`CORE_REG_BITS-1:0] rs1,
  input  logic [`CORE_REG_BITS-1:0] rs2,
  output logic [`CORE_XLEN-1:0]     rd1,
  output logic [`CORE_XLEN-1:0]     rd2,
  input  core_pkg::wb_t             wb
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  // write port, x0 never stored
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wen && (wb.waddr != '0)) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  // read ports
  // a write landing this cycle is seen right away
  always_comb begin
    if (rs1 == '0) rd1 = '0;
    else if (wb.wen && (wb.waddr == rs1)) rd1 = wb.wdata;
    else rd1 = regs[rs1];
  end

  always_comb begin
    if (rs2 == '0) rd2 = '0;
    else if (wb.wen && (wb.waddr == rs2)) rd2 = wb.wdata;
    else rd2 = regs[rs2];
  end

endmodule

// File: files.f
+incdir+design
design/core_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/commit_queue.sv
design/mini_core.sv
sim/mini_core_assertions.sv
sim/mini_core_tb.sv

// File: sim/mini_core_assertions.sv
/*
 * bound checks on the core boundary: stream stability under
 * back-pressure, quiet outputs in reset, one-cycle squash
 */

`timescale 1ns/10ps

module mini_core_assertions (
  input logic                  clk,
  input logic                  rst,
  input logic                  inst_rdy,
  input logic                  commit_val,
  input logic                  commit_rdy,
  input core_pkg::commit_msg_t commit_msg,
  input logic                  squash
);

  // failed properties so far
  int unsigned fail_count = 0;

  // ----------------------------------------
  // val/rdy stability
  // a stalled commit record holds still until taken
  commit_hold_a: assert property (@(posedge clk) disable iff (rst)
      commit_val && !commit_rdy |=> commit_val && $stable(commit_msg))
    else begin
      $error("commit record changed or dropped while commit_rdy was low");
      fail_count++;
    end

  // ----------------------------------------
  // reset and squash behavior
  reset_quiet_a: assert property (@(posedge clk)
      rst && $past(rst) |-> !commit_val && !squash)
    else begin
      $error("commit_val or squash high during reset");
      fail_count++;
    end

  // empty slots once reset drops
  ready_after_reset_a: assert property (@(posedge clk) $fell(rst) |-> inst_rdy)
    else begin
      $error("inst_rdy low right after reset release");
      fail_count++;
    end

  squash_single_a: assert property (@(posedge clk) disable iff (rst)
      squash |=> !squash)
    else begin
      $error("squash held for two consecutive cycles");
      fail_count++;
    end

endmodule

// File: sim/mini_core_tb.sv
/*
 * testbench for the mini core: clock and reset, LCG program generation,
 * in-order ISA reference model, commit record checks
 */

`timescale 1ns/10ps

module mini_core_tb;

  // ----------------------------------------
  // instruction spec kept beside each encoded word
  typedef enum logic [3:0] {
    op_add, op_sub, op_and, op_or, op_xor, op_addi, op_andi, op_ori, op_xori,
    op_beq, op_bne, op_bad
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
  } spec_t;

  // rv32i major opcodes
  localparam logic [6:0] opc_r = 7'b0110011;
  localparam logic [6:0] opc_i = 7'b0010011;
  localparam logic [6:0] opc_b = 7'b1100011;
  localparam int prog_len   = 112;
  localparam int wait_limit = 400;

  logic                  clk;
  logic                  rst;
  logic                  inst_val;
  logic                  inst_rdy;
  core_pkg::fetch_msg_t  inst_msg;
  logic                  commit_val;
  logic                  commit_rdy;
  core_pkg::commit_msg_t commit_msg;

  spec_t                 prog[$];
  core_pkg::commit_msg_t expected[$];
  logic [31:0]           rand_state = 32'hbc97;
  logic                  run_done;

  mini_core mini_core_i (
    .clk        (clk),
    .rst        (rst),
    .inst_val   (inst_val),
    .inst_rdy   (inst_rdy),
    .inst_msg   (inst_msg),
    .commit_val (commit_val),
    .commit_rdy (commit_rdy),
    .commit_msg (commit_msg)
  );

  bind mini_core mini_core_assertions mini_core_assertions_i (
    .clk        (clk),
    .rst        (rst),
    .inst_rdy   (inst_rdy),
    .commit_val (commit_val),
    .commit_rdy (commit_rdy),
    .commit_msg (commit_msg),
    .squash     (redirect.squash)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // stop at the first bound assertion failure
  always @(negedge clk) begin
    if (mini_core_i.mini_core_assertions_i.fail_count != 0) begin
      $display("bound assertion failed, see the error above");
      abort_run();
    end
  end

  // ----------------------------------------
  // helpers
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // encodings straight from the rv32i formats
  function automatic logic [31:0] encode(input spec_t s);
    case (s.op)
      op_add:  return {7'b0000000, s.rs2, s.rs1, 3'b000, s.rd, opc_r};
      op_sub:  return {7'b0100000, s.rs2, s.rs1, 3'b000, s.rd, opc_r};
      op_and:  return {7'b0000000, s.rs2, s.rs1, 3'b111, s.rd, opc_r};
      op_or:   return {7'b0000000, s.rs2, s.rs1, 3'b110, s.rd, opc_r};
      op_xor:  return {7'b0000000, s.rs2, s.rs1, 3'b100, s.rd, opc_r};
      op_addi: return {s.imm[11:0], s.rs1, 3'b000, s.rd, opc_i};
      op_andi: return {s.imm[11:0], s.rs1, 3'b111, s.rd, opc_i};
      op_ori:  return {s.imm[11:0], s.rs1, 3'b110, s.rd, opc_i};
      op_xori: return {s.imm[11:0], s.rs1, 3'b100, s.rd, opc_i};
      op_beq:  return {s.imm[12], s.imm[10:5], s.rs2, s.rs1, 3'b000,
                       s.imm[4:1], s.imm[11], opc_b};
      op_bne:  return {s.imm[12], s.imm[10:5], s.rs2, s.rs1, 3'b001,
                       s.imm[4:1], s.imm[11], opc_b};
      // lw, outside the subset
      default: return {s.imm[11:0], s.rs1, 3'b010, s.rd, 7'b0000011};
    endcase
  endfunction

  task automatic append_inst(input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] imm);
    prog.push_back(spec_t'{op, rd, rs1, rs2, imm});
  endtask

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic value_error(input string test, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    $display("** Error %s: expected 0x%08h, actual 0x%08h", test, exp_val, act_val);
    abort_run();
  endtask

  task automatic timeout_error(input string what);
    $display("Timeout, %s", what);
    abort_run();
  endtask

  // ----------------------------------------
  // program and reference model
  task automatic build_program();
    logic [31:0] r;
    logic [31:0] imm_r;
    logic [31:0] imm;
    op_e         op;
    // preload x1..x7 with sign-extended immediates
    for (int k = 1; k < 8; k++) begin
      r = next_rand();
      append_inst(op_addi, 5'(k), 5'd0, 5'd0, sext12(r[31:20]));
    end
    // x0 writes commit, x0 reads stay zero
    append_inst(op_addi, 5'd0, 5'd1, 5'd0, 32'd5);
    append_inst(op_xor, 5'd0, 5'd2, 5'd3, 32'd0);
    append_inst(op_add, 5'd8, 5'd0, 5'd2, 32'd0);
    // back-to-back dependent chain
    append_inst(op_addi, 5'd10, 5'd1, 5'd0, 32'd3);
    append_inst(op_add, 5'd11, 5'd10, 5'd10, 32'd0);
    append_inst(op_sub, 5'd12, 5'd11, 5'd10, 32'd0);
    append_inst(op_xori, 5'd13, 5'd12, 5'd0, 32'hffff_ffff);
    // taken beq over two wrong-path words, then a not-taken bne
    append_inst(op_beq, 5'd0, 5'd1, 5'd1, 32'd12);
    append_inst(op_addi, 5'd14, 5'd0, 5'd0, 32'd1);
    append_inst(op_addi, 5'd15, 5'd0, 5'd0, 32'd2);
    append_inst(op_bne, 5'd0, 5'd4, 5'd4, 32'd8);
    append_inst(op_or, 5'd14, 5'd13, 5'd1, 32'd0);
    append_inst(op_bne, 5'd0, 5'd0, 5'd14, 32'd8);
    append_inst(op_and, 5'd15, 5'd0, 5'd0, 32'd0);
    // random body on x0..x7, forward branches only
    while (prog.size() < prog_len) begin
      r     = next_rand();
      imm_r = next_rand();
      op    = op_e'(r[31:28] % 4'd12);
      if (op == op_beq || op == op_bne) imm = {27'd0, imm_r[30:29], 3'b000} + 32'd4;
      else imm = sext12(imm_r[27:16]);
      append_inst(op, 5'(r[26:24]), 5'(r[22:20]), 5'(r[18:16]), imm);
    end
  endtask

  // walks the program in order, following taken branches
  task automatic build_expected();
    logic [31:0] regs [32];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        taken;
    spec_t       s;
    int          i;
    for (int k = 0; k < 32; k++) begin
      regs[k] = '0;
    end
    i = 0;
    while (i < prog.size()) begin
      s     = prog[i];
      pc    = 32'(i * 4);
      a     = regs[s.rs1];
      b     = regs[s.rs2];
      rd    = s.rd;
      taken = 1'b0;
      case (s.op)
        op_add:  value = a + b;
        op_sub:  value = a - b;
        op_and:  value = a & b;
        op_or:   value = a | b;
        op_xor:  value = a ^ b;
        op_addi: value = a + s.imm;
        op_andi: value = a & s.imm;
        op_ori:  value = a | s.imm;
        op_xori: value = a ^ s.imm;
        op_beq, op_bne: begin
          taken = (s.op == op_beq) ? (a == b) : (a != b);
          value = taken ? pc + s.imm : pc + 32'd4;
          rd    = '0;
        end
        default: begin
          value = '0;
          rd    = '0;
        end
      endcase
      // x0 never changes
      if (rd != '0) regs[rd] = value;
      expected.push_back(core_pkg::commit_msg_t'{pc, rd, value});
      i = taken ? i + int'(s.imm >> 2) : i + 1;
    end
  endtask

  // ----------------------------------------
  // stream drivers and checker
  task automatic feed_program();
    int cycles;
    for (int i = 0; i < prog.size(); i++) begin
      @(negedge clk);
      inst_val = 1'b1;
      inst_msg = {32'(i * 4), encode(prog[i])};
      #1;
      cycles = 0;
      while (!inst_rdy) begin
        cycles++;
        if (cycles > wait_limit) timeout_error($sformatf("word %0d never accepted", i));
        @(negedge clk);
        #1;
      end
      @(posedge clk);
    end
    @(negedge clk);
    inst_val = 1'b0;
  endtask

  task automatic drive_commit_rdy();
    logic [31:0] r;
    int          cycles;
    cycles = 0;
    while (!run_done) begin
      @(negedge clk);
      r          = next_rand();
      commit_rdy = (r[31:29] > 3'd1);
      cycles++;
      if (cycles > 100 * wait_limit) timeout_error("commit_rdy driver ran past its limit");
    end
  endtask

  task automatic collect_commits();
    core_pkg::commit_msg_t exp_rec;
    int                    cycles;
    int                    n;
    n = expected.size();
    for (int k = 0; k < n; k++) begin
      exp_rec = expected.pop_front();
      cycles  = 0;
      do begin
        @(negedge clk);
        #1;
        cycles++;
        if (cycles > wait_limit) timeout_error($sformatf("commit %0d never arrived", k));
      end while (!(commit_val && commit_rdy));
      assert (commit_msg.pc == exp_rec.pc)
        else value_error($sformatf("commit %0d pc", k), exp_rec.pc, commit_msg.pc);
      assert (commit_msg.rd == exp_rec.rd)
        else value_error($sformatf("commit %0d rd", k), 32'(exp_rec.rd), 32'(commit_msg.rd));
      assert (commit_msg.value == exp_rec.value)
        else value_error($sformatf("commit %0d value", k), exp_rec.value, commit_msg.value);
    end
    // wrong-path tail must stay silent
    for (int k = 0; k < 40; k++) begin
      @(negedge clk);
      #1;
      assert (!commit_val) else begin
        $display("unexpected commit record after the last one, pc 0x%08h", commit_msg.pc);
        abort_run();
      end
    end
  endtask

  initial begin
    rst        = 1'b1;
    inst_val   = 1'b0;
    inst_msg   = '0;
    commit_rdy = 1'b0;
    run_done   = 1'b0;
    build_program();
    build_expected();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fork
      feed_program();
      drive_commit_rdy();
      begin
        collect_commits();
        run_done = 1'b1;
      end
    join
    if (mini_core_i.mini_core_assertions_i.fail_count != 0) begin
      $display("%0d bound assertion failures", mini_core_i.mini_core_assertions_i.fail_count);
      abort_run();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule
